// File: source/vic_media_pkg.sv
//////////////////////////////////////////////////////////////////////
// VIC media package
// Download bus, configuration write and memory choice types shared
// by the loader, tape and clocking blocks
//////////////////////////////////////////////////////////////////////

`default_nettype none

package vic_media_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus structures

	// Host download bus, one byte per wr strobe
	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_bus_t;

	// Single write toward the machine configuration bus
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        wr;
	} conf_wr_t;

	// User memory choices
	typedef struct packed {
		logic       ram1;
		logic [1:0] ram2_sel;
		logic       ram3;
		logic       cart_writable;
	} ext_cfg_t;

	// Bit 0 is $0400, bits 1..3 are $2000/$4000/$6000, bit 4 is $A000
	typedef logic [4:0] blk_mask_t;

	//////////////////////////////////////////////////////////////////////
	// Download file kinds

	localparam logic [7:0] IDX_PRG  = 8'd1;
	localparam logic [7:0] IDX_CART = 8'd2;
	localparam logic [7:0] IDX_TAPE = 8'd5;

	// First address that is no longer written
	localparam logic [15:0] PRG_LIMIT  = 16'hA000;
	localparam logic [15:0] CART_LIMIT = 16'hC000;

	// BASIC end pointers in write order, low byte at even positions
	localparam logic [0:7][15:0] END_PTR_ADDR = {
		16'h002d, 16'h002e, 16'h002f, 16'h0030,
		16'h0031, 16'h0032, 16'h00ae, 16'h00af
	};

	//////////////////////////////////////////////////////////////////////
	// Clock rates in Hz

	localparam logic [31:0] SYS_HZ_PAL  = 32'd35468944;
	localparam logic [31:0] SYS_HZ_NTSC = 32'd32727260;
	localparam logic [31:0] DRIVE_HZ    = 32'd32000000;

endpackage

`default_nettype wire

// File: source/prg_loader.sv
//////////////////////////////////////////////////////////////////////
// Program and cartridge loader
// Turns host downloads into configuration bus writes, writes the BASIC
// end pointers and decodes the expansion memory map
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module prg_loader (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire vic_media_pkg::dl_bus_t  dl_i,
	input  wire vic_media_pkg::ext_cfg_t ext_cfg_i,
	output vic_media_pkg::conf_wr_t   conf_wr_o,
	output vic_media_pkg::blk_mask_t  ram_ext_o,
	output vic_media_pkg::blk_mask_t  ram_ext_ro_o
);
	import vic_media_pkg::*;

	logic        active_q;
	logic [3:0]  ptr_state;
	logic [15:0] load_addr;
	logic [15:0] load_limit;
	blk_mask_t   cart_blk;
	blk_mask_t   blk_hit;
	logic [2:0]  ram2_blk;
	logic        is_prg;
	logic        is_cart;
	logic        prg_end;

	assign is_prg  = dl_i.active && (dl_i.index == IDX_PRG);
	assign is_cart = dl_i.active && (dl_i.index == IDX_CART);

	// Falling download edge while the program index is still presented
	assign prg_end = active_q && !dl_i.active && (dl_i.index == IDX_PRG);

	assign load_limit = is_prg ? PRG_LIMIT : CART_LIMIT;

	// 8 KB block hit by the current load address
	always_comb begin
		blk_hit = '0;
		case (load_addr[15:13])
			3'b000: blk_hit[0] = 1'b1;
			3'b001: blk_hit[1] = 1'b1;
			3'b010: blk_hit[2] = 1'b1;
			3'b011: blk_hit[3] = 1'b1;
			3'b101: blk_hit[4] = 1'b1;
			default: blk_hit = '0;
		endcase
	end

	// RAM 2 choice covers one, two or three blocks from $2000
	always_comb begin
		case (ext_cfg_i.ram2_sel)
			2'd0: ram2_blk = 3'b000;
			2'd1: ram2_blk = 3'b001;
			2'd2: ram2_blk = 3'b011;
			default: ram2_blk = 3'b111;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Download to configuration writes

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q     <= 1'b0;
			ptr_state    <= 4'd0;
			cart_blk     <= '0;
			conf_wr_o.wr <= 1'b0;
			ram_ext_o    <= '0;
			ram_ext_ro_o <= '0;
		end else begin
			active_q     <= dl_i.active;
			conf_wr_o.wr <= 1'b0;

			// Two header bytes give the load address, low byte first
			if ((is_prg || is_cart) && dl_i.wr) begin
				if (dl_i.addr == 25'd0) begin
					load_addr[7:0] <= dl_i.data;
				end else if (dl_i.addr == 25'd1) begin
					load_addr[15:8] <= dl_i.data;
				end else if (load_addr < load_limit) begin
					conf_wr_o.addr <= load_addr;
					conf_wr_o.data <= dl_i.data;
					conf_wr_o.wr   <= 1'b1;
					load_addr      <= load_addr + 16'd1;
					if (is_cart) begin
						cart_blk <= cart_blk | blk_hit;
					end
				end
			end

			// Pointer sequence runs over 16 states, writing on odd ones
			if (prg_end) begin
				ptr_state <= 4'd1;
			end else if (is_prg) begin
				ptr_state <= 4'd0;
			end else if (ptr_state != 4'd0) begin
				ptr_state <= ptr_state + 4'd1;
			end

			if (ptr_state[0]) begin
				conf_wr_o.addr <= END_PTR_ADDR[ptr_state[3:1]];
				conf_wr_o.data <= ptr_state[1] ? load_addr[15:8] : load_addr[7:0];
				conf_wr_o.wr   <= 1'b1;
			end

			// Memory map follows the mask one cycle late
			ram_ext_o    <= {ext_cfg_i.ram3, ram2_blk, ext_cfg_i.ram1} | cart_blk;
			ram_ext_ro_o <= ext_cfg_i.cart_writable ? '0 : cart_blk;
		end
	end

endmodule

`default_nettype wire

// File: source/tape_buffer.sv
//////////////////////////////////////////////////////////////////////
// Tape image buffer
// Stores a downloaded tape image and feeds it byte by byte to the
// cassette FIFO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tape_buffer #(
	parameter int TAPE_ADDR_W = 16
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire vic_media_pkg::dl_bus_t dl_i,
	input  wire                         play_btn_i,
	input  wire                         unload_i,
	input  wire                         fifo_full_i,
	output logic [7:0]                  tape_byte_o,
	output logic                        tape_valid_o,
	output logic                        tape_play_o,
	output logic                        tape_loaded_o
);
	import vic_media_pkg::*;

	localparam int DEPTH = 2 ** TAPE_ADDR_W;
	localparam int CNT_W = TAPE_ADDR_W + 1;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_READ,
		FETCH_VALID
	} fetch_st_t;

	logic [7:0]       tape_mem [DEPTH];
	logic [CNT_W-1:0] end_addr;
	logic [CNT_W-1:0] play_addr;
	logic [CNT_W-1:0] byte_cnt;
	fetch_st_t        fetch_st;
	logic             tape_dl;
	logic             btn_q;
	logic             loaded_q;

	assign tape_dl       = dl_i.active && (dl_i.index == IDX_TAPE);
	assign tape_loaded_o = play_addr < end_addr;

	// Byte count so far, capped at the buffer depth
	always_comb begin
		if (dl_i.addr >= 25'(DEPTH)) begin
			byte_cnt = CNT_W'(DEPTH);
		end else begin
			byte_cnt = CNT_W'(dl_i.addr) + 1'b1;
		end
	end

	// Image store
	always_ff @(posedge clk_sys) begin
		if (tape_dl && dl_i.wr && (dl_i.addr < 25'(DEPTH))) begin
			tape_mem[dl_i.addr[TAPE_ADDR_W-1:0]] <= dl_i.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Play control and byte fetch

	always_ff @(posedge clk_sys) begin
		if (reset || unload_i || tape_dl) begin
			play_addr    <= '0;
			fetch_st     <= FETCH_IDLE;
			tape_valid_o <= 1'b0;
			btn_q        <= 1'b0;
			loaded_q     <= 1'b0;
			// Playback starts on its own once the image is in
			tape_play_o  <= tape_dl && !reset && !unload_i;
			if (reset || unload_i) begin
				end_addr <= '0;
			end else if (dl_i.wr) begin
				end_addr <= byte_cnt;
			end
		end else begin
			btn_q        <= play_btn_i;
			loaded_q     <= tape_loaded_o;
			tape_valid_o <= 1'b0;

			if (play_btn_i && !btn_q) begin
				tape_play_o <= !tape_play_o;
			end
			// End of image stops play
			if (loaded_q && !tape_loaded_o) begin
				tape_play_o <= 1'b0;
			end

			// Issue, read, then present the byte
			case (fetch_st)
				FETCH_IDLE: begin
					if (tape_loaded_o && !fifo_full_i) begin
						fetch_st <= FETCH_READ;
					end
				end
				FETCH_READ: begin
					tape_byte_o  <= tape_mem[play_addr[TAPE_ADDR_W-1:0]];
					tape_valid_o <= 1'b1;
					fetch_st     <= FETCH_VALID;
				end
				FETCH_VALID: begin
					play_addr <= play_addr + 1'b1;
					fetch_st  <= FETCH_IDLE;
				end
				default: fetch_st <= FETCH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/clock_enables.sv
//////////////////////////////////////////////////////////////////////
// Clock enables
// CPU divide-by-N enable and fractional drive enable for PAL or NTSC
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module clock_enables #(
	parameter int CPU_DIV = 4
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  pal_i,
	output logic cpu_ce_o,
	output logic drive_ce_o
);
	import vic_media_pkg::*;

	localparam int DIV_W = $clog2(CPU_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic [31:0]      acc;
	logic [31:0]      acc_sum;
	logic [31:0]      modulus;

	assign acc_sum = acc + DRIVE_HZ;

	// System rate for the current video standard
	always_ff @(posedge clk_sys) begin
		modulus <= pal_i ? SYS_HZ_PAL : SYS_HZ_NTSC;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt    <= '0;
			acc        <= '0;
			cpu_ce_o   <= 1'b0;
			drive_ce_o <= 1'b0;
		end else begin
			div_cnt  <= (div_cnt == DIV_W'(CPU_DIV - 1)) ? '0 : div_cnt + 1'b1;
			cpu_ce_o <= (div_cnt == DIV_W'(CPU_DIV - 1));

			// Drive rate out of the system rate by accumulation
			if (acc_sum >= modulus) begin
				acc        <= acc_sum - modulus;
				drive_ce_o <= 1'b1;
			end else begin
				acc        <= acc_sum;
				drive_ce_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/tape_activity_led.sv
//////////////////////////////////////////////////////////////////////
// Tape activity LED
// Slow fading indicator for a loaded tape, lit through any download
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tape_activity_led (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  downloading_i,
	input  wire  tape_loaded_i,
	input  wire  tape_play_i,
	input  wire  motor_i,
	output logic led_o
);

	logic [26:0] act_cnt;
	logic        fade_out;
	logic        tape_ind;

	// Sweeps faster while the tape plays
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			act_cnt <= '0;
		end else begin
			act_cnt <= act_cnt + (tape_play_i ? 27'd8 : 27'd1);
		end
	end

	// Duty cycle from slow bits against fast bits
	assign fade_out = !(tape_play_i && motor_i) && (act_cnt[25:18] > act_cnt[7:0]);
	assign tape_ind = tape_loaded_i && (act_cnt[26] ? fade_out : (act_cnt[25:18] <= act_cnt[7:0]));

	assign led_o = downloading_i || tape_ind;

endmodule

`default_nettype wire

// File: source/media_top.sv
//////////////////////////////////////////////////////////////////////
// Media top level
// Loader, tape buffer, clock enables and activity LED
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module media_top #(
	parameter int TAPE_ADDR_W = 16,
	parameter int CPU_DIV     = 4
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire vic_media_pkg::dl_bus_t  dl_i,
	input  wire vic_media_pkg::ext_cfg_t ext_cfg_i,
	input  wire                          play_btn_i,
	input  wire                          unload_i,
	input  wire                          fifo_full_i,
	input  wire                          motor_i,
	input  wire                          pal_i,
	output wire vic_media_pkg::conf_wr_t  conf_wr_o,
	output wire vic_media_pkg::blk_mask_t ram_ext_o,
	output wire vic_media_pkg::blk_mask_t ram_ext_ro_o,
	output wire [7:0]                    tape_byte_o,
	output wire                          tape_valid_o,
	output wire                          tape_play_o,
	output wire                          tape_loaded_o,
	output wire                          cpu_ce_o,
	output wire                          drive_ce_o,
	output wire                          led_o
);

	prg_loader u_prg_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_i         (dl_i),
		.ext_cfg_i    (ext_cfg_i),
		.conf_wr_o    (conf_wr_o),
		.ram_ext_o    (ram_ext_o),
		.ram_ext_ro_o (ram_ext_ro_o)
	);

	tape_buffer #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) u_tape_buffer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_i          (dl_i),
		.play_btn_i    (play_btn_i),
		.unload_i      (unload_i),
		.fifo_full_i   (fifo_full_i),
		.tape_byte_o   (tape_byte_o),
		.tape_valid_o  (tape_valid_o),
		.tape_play_o   (tape_play_o),
		.tape_loaded_o (tape_loaded_o)
	);

	clock_enables #(
		.CPU_DIV (CPU_DIV)
	) u_clock_enables (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pal_i      (pal_i),
		.cpu_ce_o   (cpu_ce_o),
		.drive_ce_o (drive_ce_o)
	);

	// LED is lit by any download, not only tape
	tape_activity_led u_tape_activity_led (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.downloading_i (dl_i.active),
		.tape_loaded_i (tape_loaded_o),
		.tape_play_i   (tape_play_o),
		.motor_i       (motor_i),
		.led_o         (led_o)
	);

endmodule

`default_nettype wire

// File: dv/media_tb.sv
//////////////////////////////////////////////////////////////////////
// Media testbench
// Program, cartridge and tape downloads, clock enables and LED
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module media_tb;
	import vic_media_pkg::*;

	localparam int TOTAL_BYTES = 26 + 9218 + 40 + 6;
	localparam int WINDOW      = 2000;
	localparam int CYC_LIMIT   = TOTAL_BYTES * 4 + 4000 + 2 * WINDOW;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        is_ptr;
	} exp_wr_t;

	logic        clk_sys = 1'b0;
	logic        reset;
	dl_bus_t     dl;
	ext_cfg_t    ext_cfg;
	logic        play_btn, unload, fifo_full, motor, pal;
	conf_wr_t    conf_wr;
	blk_mask_t   ram_ext, ram_ext_ro;
	logic [7:0]  tape_byte;
	logic        tape_valid, tape_play, tape_loaded, cpu_ce, drive_ce, led;

	exp_wr_t     exp_q[$];
	logic [7:0]  tape_q[$];
	logic [7:0]  file_q[$];
	logic [31:0] seed = 32'hfd62_63d9;
	string       cur_test = "reset";
	int          cyc = 0;
	int          last_ptr_cyc = 0;
	int          last_cpu_cyc = 0;
	int          full_cnt = 0;
	int          tape_rx = 0;

	media_top #(.TAPE_ADDR_W(8), .CPU_DIV(4)) DUT (
		.clk_sys(clk_sys), .reset(reset), .dl_i(dl), .ext_cfg_i(ext_cfg),
		.play_btn_i(play_btn), .unload_i(unload), .fifo_full_i(fifo_full),
		.motor_i(motor), .pal_i(pal), .conf_wr_o(conf_wr), .ram_ext_o(ram_ext),
		.ram_ext_ro_o(ram_ext_ro), .tape_byte_o(tape_byte), .tape_valid_o(tape_valid),
		.tape_play_o(tape_play), .tape_loaded_o(tape_loaded), .cpu_ce_o(cpu_ce),
		.drive_ce_o(drive_ce), .led_o(led)
	);

	always #4 clk_sys = !clk_sys;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic mismatch(input string what, input logic [31:0] e, input logic [31:0] a);
		fail_run($sformatf("error %s %s: expected %0h actual %0h", cur_test, what, e, a));
	endtask

	function automatic logic [7:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:24];
	endfunction

	// Expansion map from the user choices alone
	function automatic blk_mask_t cfg_decode(input ext_cfg_t c);
		blk_mask_t m;
		m = {c.ram3, 3'b000, c.ram1};
		if (c.ram2_sel >= 2'd1) m[1] = 1'b1;
		if (c.ram2_sel >= 2'd2) m[2] = 1'b1;
		if (c.ram2_sel == 2'd3) m[3] = 1'b1;
		return m;
	endfunction

	// Block bit that a cartridge address occupies, if any
	function automatic blk_mask_t block_of(input logic [15:0] a);
		blk_mask_t m;
		m = '0;
		if (a < 16'h0400) m = '0;
		else if (a < 16'h2000) m[0] = 1'b1;
		else if (a < 16'h8000) m[a[14:13]] = 1'b1;
		else if (a >= 16'hA000 && a < 16'hC000) m[4] = 1'b1;
		return m;
	endfunction

	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic send_file(input logic [7:0] idx);
		for (int i = 0; i < file_q.size(); i++) begin
			dl = '{active: 1'b1, index: idx, wr: 1'b1, addr: 25'(i), data: file_q[i]};
			step(1);
		end
		dl.wr = 1'b0;
		step(1);
		dl.active = 1'b0;
		step(4);
	endtask

	// Header plus payload, queueing the writes that land below the limit
	task automatic build_load(input logic [15:0] base, input int n, input logic [15:0] lim);
		logic [7:0] b;
		file_q.delete();
		file_q.push_back(base[7:0]);
		file_q.push_back(base[15:8]);
		for (int i = 0; i < n; i++) begin
			b = next_rand();
			file_q.push_back(b);
			if (base + 16'(i) < lim) begin
				exp_q.push_back('{base + 16'(i), b, 1'b0});
			end
		end
	endtask

	task automatic check_drive(input logic p);
		int cnt;
		longint lhs, rhs, modv;
		cnt = 0;
		pal = p;
		step(4);
		repeat (WINDOW) begin
			step(1);
			if (drive_ce) cnt++;
		end
		modv = p ? longint'(SYS_HZ_PAL) : longint'(SYS_HZ_NTSC);
		lhs = longint'(cnt) * modv;
		rhs = longint'(WINDOW) * longint'(DRIVE_HZ);
		assert ((lhs - rhs <= modv) && (rhs - lhs <= modv))
			else mismatch("drive pulses", 32'(rhs / modv), cnt);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitors

	always @(posedge clk_sys) begin
		exp_wr_t e;
		cyc++;
		assert (cyc < CYC_LIMIT) else fail_run("Run did not finish within the cycle limit");
		if (reset) begin
			// First CPU enable comes four cycles after reset is released
			last_cpu_cyc = cyc + 1;
		end else begin
			if (conf_wr.wr) begin
				assert (exp_q.size() != 0) else fail_run("Configuration write with none expected");
				e = exp_q.pop_front();
				assert (conf_wr.addr == e.addr)
					else mismatch("write address", e.addr, conf_wr.addr);
				assert (conf_wr.data == e.data)
					else mismatch("write data", e.data, conf_wr.data);
				if (e.is_ptr) begin
					assert (last_ptr_cyc == 0 || cyc - last_ptr_cyc == 2)
						else mismatch("pointer spacing", 2, cyc - last_ptr_cyc);
					last_ptr_cyc = cyc;
				end
			end
			if (cpu_ce) begin
				assert (cyc - last_cpu_cyc == 4)
					else mismatch("cpu enable period", 4, cyc - last_cpu_cyc);
				last_cpu_cyc = cyc;
			end else begin
				assert (cyc - last_cpu_cyc < 4) else fail_run("CPU enable did not come in time");
			end
			full_cnt = fifo_full ? full_cnt + 1 : 0;
			if (tape_valid) begin
				assert (full_cnt <= 2) else fail_run("Tape byte issued while the FIFO was full");
				assert (tape_q.size() != 0) else fail_run("Tape byte with none expected");
				assert (tape_byte == tape_q[0]) else mismatch("tape byte", tape_q[0], tape_byte);
				void'(tape_q.pop_front());
				tape_rx++;
			end
			assert (!dl.active || led) else fail_run("LED dark during a download");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		reset = 1'b1;
		dl = '0;
		ext_cfg = '0;
		{play_btn, unload, fifo_full, motor, pal} = 5'b00001;
		repeat (16) @(posedge clk_sys);
		#1 reset = 1'b0;
		step(2);
		cur_test = "led idle";
		assert (!led) else mismatch("led", 0, led);

		cur_test = "program";
		build_load(16'h9FF0, 24, PRG_LIMIT);
		for (int i = 0; i < 8; i++) begin
			exp_q.push_back('{END_PTR_ADDR[i], i[0] ? 8'hA0 : 8'h00, 1'b1});
		end
		send_file(IDX_PRG);
		while (exp_q.size() != 0) step(1);

		cur_test = "cartridge";
		ext_cfg = '{ram1: 1'b1, ram2_sel: 2'd0, ram3: 1'b0, cart_writable: 1'b0};
		build_load(16'h6000, 9216, CART_LIMIT);
		send_file(IDX_CART);
		while (exp_q.size() != 0) step(1);
		step(2);
		assert (ram_ext == (cfg_decode(ext_cfg) | block_of(16'h6000) | block_of(16'h83FF)))
			else mismatch("ram_ext", cfg_decode(ext_cfg) | block_of(16'h6000), ram_ext);
		assert (ram_ext_ro == block_of(16'h6000))
			else mismatch("ram_ext_ro", 5'b01000, ram_ext_ro);
		ext_cfg.cart_writable = 1'b1;
		step(2);
		assert (ram_ext_ro == '0) else mismatch("ram_ext_ro writable", 0, ram_ext_ro);

		cur_test = "reset mask";
		ext_cfg.cart_writable = 1'b0;
		reset = 1'b1;
		step(2);
		reset = 1'b0;
		for (int s = 0; s < 4; s++) begin
			ext_cfg.ram2_sel = 2'(s);
			step(3);
			assert (ram_ext == cfg_decode(ext_cfg))
				else mismatch("ram_ext", cfg_decode(ext_cfg), ram_ext);
			assert (ram_ext_ro == '0) else mismatch("ram_ext_ro", 0, ram_ext_ro);
			assert (!led) else mismatch("led", 0, led);
		end

		cur_test = "tape";
		file_q.delete();
		for (int i = 0; i < 40; i++) file_q.push_back(next_rand());
		tape_q = file_q;
		send_file(IDX_TAPE);
		assert (tape_play) else mismatch("play after download", 1, tape_play);
		while (tape_rx < 10) step(1);
		fifo_full = 1'b1;
		step(20);
		fifo_full = 1'b0;
		while (tape_loaded) step(1);
		step(3);
		assert (tape_rx == 40) else mismatch("tape byte count", 40, tape_rx);
		assert (!tape_play) else mismatch("play after end", 0, tape_play);
		play_btn = 1'b1;
		step(1);
		play_btn = 1'b0;
		step(3);
		assert (tape_play) else mismatch("play toggle", 1, tape_play);
		fifo_full = 1'b1;
		file_q.delete();
		for (int i = 1; i <= 6; i++) file_q.push_back(8'(i * 17));
		send_file(IDX_TAPE);
		assert (tape_loaded) else mismatch("loaded", 1, tape_loaded);
		unload = 1'b1;
		step(1);
		unload = 1'b0;
		step(2);
		assert (!tape_loaded) else mismatch("loaded after unload", 0, tape_loaded);
		fifo_full = 1'b0;

		cur_test = "clock enables";
		check_drive(1'b1);
		check_drive(1'b0);
		step(4);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
source/vic_media_pkg.sv
source/prg_loader.sv
source/tape_buffer.sv
source/clock_enables.sv
source/tape_activity_led.sv
source/media_top.sv
dv/media_tb.sv

// File: Makefile
# Verilator build and run of the media testbench

VERILATOR ?= verilator
TOP       ?= media_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
